// ==== include/conv_settings.svh ====
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// feature map and kernel geometry
`define CONV_FM_DIM         8
`define CONV_WT_DIM         3
`define CONV_OUT_DIM        6

`define CONV_DWIDTH         32
`define CONV_AWIDTH         32
`define CONV_MEM_AWIDTH     14
`define CONV_MEM_DEPTH      16384
`define CONV_TAP_W          4    // holds tap index 0..8
`define CONV_POS_W          3    // holds output row/col 0..5

// host address map
`define CONV_DMEM_BASE      32'h1000_0000
`define CONV_CSR_BASE       32'h8000_0040
`define CONV_REG_CTRL       0
`define CONV_REG_STATUS     4
`define CONV_REG_WT         8
`define CONV_REG_IFM        12
`define CONV_REG_OFM        16

// word offsets after reset, packed back to back
`define CONV_WT_OFFSET_RST  0
`define CONV_IFM_OFFSET_RST 9
`define CONV_OFM_OFFSET_RST 73

`endif

// ==== rtl/conv_pkg.sv ====
`include "conv_settings.svh"

package conv_pkg;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_LOAD_WT = 3'd1,
        ST_READ    = 3'd2,
        ST_DRAIN   = 3'd3,
        ST_WRITE   = 3'd4,
        ST_DONE    = 3'd5
    } conv_state_t;

    // kind of memory access the engine is making
    typedef enum logic [1:0] {
        PH_WT  = 2'd0,
        PH_IFM = 2'd1,
        PH_OFM = 2'd2
    } conv_phase_t;

    typedef struct packed {
        logic [`CONV_DWIDTH-3:0] rsvd;
        logic                    done;
        logic                    idle;      // bit 0
    } conv_status_t;

    typedef struct packed {
        logic [`CONV_DWIDTH-3:0] rsvd;
        logic                    soft_rst;
        logic                    start;     // bit 0
    } conv_ctrl_t;

endpackage

// ==== rtl/conv_addr_gen.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_addr_gen import conv_pkg::*; (
    input  conv_phase_t                 phase_i,
    input  logic [`CONV_TAP_W-1:0]      tap_i,
    input  logic [`CONV_POS_W-1:0]      row_i,
    input  logic [`CONV_POS_W-1:0]      col_i,
    input  logic [`CONV_DWIDTH-1:0]     wt_offset_i,
    input  logic [`CONV_DWIDTH-1:0]     ifm_offset_i,
    input  logic [`CONV_DWIDTH-1:0]     ofm_offset_i,
    output logic [`CONV_MEM_AWIDTH-1:0] addr_o
);
    logic [`CONV_DWIDTH-1:0] tap_row;
    logic [`CONV_DWIDTH-1:0] tap_col;
    logic [`CONV_DWIDTH-1:0] pix_row;
    logic [`CONV_DWIDTH-1:0] pix_col;
    logic [`CONV_DWIDTH-1:0] addr_full;

    // kernel position of this tap
    assign tap_row = tap_i / `CONV_WT_DIM;
    assign tap_col = tap_i % `CONV_WT_DIM;

    assign pix_row = row_i + tap_row;    // no padding, window stays inside the map
    assign pix_col = col_i + tap_col;

    always_comb begin
        case (phase_i)
            PH_WT:   addr_full = wt_offset_i + tap_i;
            PH_IFM:  addr_full = ifm_offset_i + pix_row * `CONV_FM_DIM + pix_col;
            PH_OFM:  addr_full = ofm_offset_i + row_i * `CONV_OUT_DIM + col_i;
            default: addr_full = '0;
        endcase
    end

    assign addr_o = addr_full[`CONV_MEM_AWIDTH-1:0];    // word address into dmem

endmodule

// ==== rtl/conv_csr.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_csr import conv_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic [`CONV_AWIDTH-1:0]   host_addr_i,
    input  logic [`CONV_DWIDTH-1:0]   host_wdata_i,
    input  logic [`CONV_DWIDTH/8-1:0] host_be_i,
    input  logic                      host_re_i,
    input  logic [`CONV_DWIDTH-1:0]   mem_rdata_i,
    input  logic                      idle_i,
    input  logic                      done_i,
    output logic                      start_o,
    output logic                      soft_rst_o,
    output logic [`CONV_DWIDTH-1:0]   wt_offset_o,
    output logic [`CONV_DWIDTH-1:0]   ifm_offset_o,
    output logic [`CONV_DWIDTH-1:0]   ofm_offset_o,
    output logic [`CONV_DWIDTH-1:0]   host_rdata_o
);
    logic [`CONV_AWIDTH-1:0] reg_off;
    logic                    reg_hit;
    logic                    reg_we;
    logic                    ctrl_we;
    conv_ctrl_t              ctrl_wr;
    conv_status_t            status;
    logic [`CONV_DWIDTH-1:0] reg_rdata;
    logic [`CONV_DWIDTH-1:0] reg_rdata_q;
    logic                    mem_sel_q;

    function automatic logic [`CONV_DWIDTH-1:0] merge_be(
        input logic [`CONV_DWIDTH-1:0]   old_val,
        input logic [`CONV_DWIDTH-1:0]   new_val,
        input logic [`CONV_DWIDTH/8-1:0] be
    );
        logic [`CONV_DWIDTH-1:0] res;
        res = old_val;
        for (int i = 0; i < `CONV_DWIDTH/8; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign reg_off = host_addr_i - `CONV_CSR_BASE;    // below base wraps to a miss
    assign reg_hit = (reg_off <= `CONV_REG_OFM) && (reg_off[1:0] == 2'b00);
    assign reg_we  = reg_hit && (|host_be_i);
    assign ctrl_we = reg_we && (reg_off == `CONV_REG_CTRL);
    assign ctrl_wr = conv_ctrl_t'(host_wdata_i);

    assign status = '{rsvd: '0, done: done_i, idle: idle_i};

    always_comb begin
        case (reg_off)
            `CONV_REG_STATUS: reg_rdata = status;
            `CONV_REG_WT:     reg_rdata = wt_offset_o;
            `CONV_REG_IFM:    reg_rdata = ifm_offset_o;
            `CONV_REG_OFM:    reg_rdata = ofm_offset_o;
            default:          reg_rdata = '0;    // ctrl reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wt_offset_o  <= `CONV_WT_OFFSET_RST;
            ifm_offset_o <= `CONV_IFM_OFFSET_RST;
            ofm_offset_o <= `CONV_OFM_OFFSET_RST;
            start_o      <= 1'b0;
            soft_rst_o   <= 1'b0;
            mem_sel_q    <= 1'b0;
        end else begin
            start_o    <= ctrl_we && ctrl_wr.start && !ctrl_wr.soft_rst;  // soft reset wins
            soft_rst_o <= ctrl_we && ctrl_wr.soft_rst;
            if (reg_we) begin
                case (reg_off)
                    `CONV_REG_WT:  wt_offset_o  <= merge_be(wt_offset_o, host_wdata_i, host_be_i);
                    `CONV_REG_IFM: ifm_offset_o <= merge_be(ifm_offset_o, host_wdata_i, host_be_i);
                    `CONV_REG_OFM: ofm_offset_o <= merge_be(ofm_offset_o, host_wdata_i, host_be_i);
                    default:       ;
                endcase
            end
            if (host_re_i) begin
                mem_sel_q <= !reg_hit;    // anything else answers from memory
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_re_i) begin
            reg_rdata_q <= reg_rdata;
        end
    end

    assign host_rdata_o = mem_sel_q ? mem_rdata_i : reg_rdata_q;

    a_start_vs_soft_rst : assert property (@(posedge clk) disable iff (rst_i)
        !(start_o && soft_rst_o));

endmodule

// ==== rtl/conv_fsm.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_fsm import conv_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  logic                   soft_rst_i,
    output conv_phase_t            phase_o,
    output logic [`CONV_TAP_W-1:0] tap_o,
    output logic [`CONV_POS_W-1:0] row_o,
    output logic [`CONV_POS_W-1:0] col_o,
    output logic                   rd_o,
    output logic                   wr_o,
    output logic                   acc_clr_o,
    output logic                   idle_o,
    output logic                   done_o
);
    localparam int LAST_TAP = `CONV_WT_DIM * `CONV_WT_DIM - 1;
    localparam int LAST_POS = `CONV_OUT_DIM - 1;

    conv_state_t            state_q;
    conv_phase_t            phase_q;
    logic [`CONV_TAP_W-1:0] tap_q;
    logic [`CONV_POS_W-1:0] row_q;
    logic [`CONV_POS_W-1:0] col_q;
    logic                   last_tap;

    assign last_tap = (tap_q == LAST_TAP);

    always_ff @(posedge clk) begin
        if (rst_i || soft_rst_i) begin
            state_q <= ST_IDLE;
            phase_q <= PH_WT;
            tap_q   <= '0;
            row_q   <= '0;
            col_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE, ST_DONE: begin
                    if (start_i) begin
                        state_q <= ST_LOAD_WT;
                        phase_q <= PH_WT;
                        tap_q   <= '0;
                        row_q   <= '0;
                        col_q   <= '0;
                    end
                end
                ST_LOAD_WT, ST_READ: begin    // one tap read per cycle
                    if (last_tap) begin
                        tap_q   <= '0;
                        state_q <= ST_DRAIN;
                    end else begin
                        tap_q <= tap_q + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    // last read data lands in the mac this cycle
                    if (phase_q == PH_WT) begin
                        state_q <= ST_READ;
                        phase_q <= PH_IFM;
                    end else begin
                        state_q <= ST_WRITE;
                        phase_q <= PH_OFM;
                    end
                end
                ST_WRITE: begin
                    phase_q <= PH_IFM;
                    state_q <= ST_READ;
                    if (col_q == LAST_POS) begin
                        col_q <= '0;
                        if (row_q == LAST_POS) begin
                            state_q <= ST_DONE;    // last output written
                        end else begin
                            row_q <= row_q + 1'b1;
                        end
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign phase_o   = phase_q;
    assign tap_o     = tap_q;
    assign row_o     = row_q;
    assign col_o     = col_q;
    assign rd_o      = (state_q == ST_LOAD_WT) || (state_q == ST_READ);
    assign wr_o      = (state_q == ST_WRITE);
    assign acc_clr_o = (state_q == ST_READ) && (tap_q == '0);    // first tap of each output
    assign idle_o    = (state_q == ST_IDLE) || (state_q == ST_DONE);
    assign done_o    = (state_q == ST_DONE);

    a_rd_wr_excl : assert property (@(posedge clk) disable iff (rst_i)
        !(rd_o && wr_o));

endmodule

// ==== rtl/conv_mac.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_mac import conv_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_i,
    input  conv_phase_t            phase_i,
    input  logic [`CONV_TAP_W-1:0] tap_i,
    input  logic                   rd_i,
    input  logic                   acc_clr_i,
    input  logic [`CONV_DWIDTH-1:0] rdata_i,
    output logic [`CONV_DWIDTH-1:0] sum_o
);
    localparam int NUM_TAPS = `CONV_WT_DIM * `CONV_WT_DIM;

    conv_phase_t                    phase_q;
    logic [`CONV_TAP_W-1:0]         tap_q;
    logic                           rd_q;
    logic signed [`CONV_DWIDTH-1:0] wt_q [NUM_TAPS];
    logic signed [2*`CONV_DWIDTH-1:0] prod;
    logic [`CONV_DWIDTH-1:0]        acc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= rd_i;    // data for this strobe arrives next cycle
        end
    end

    always_ff @(posedge clk) begin
        phase_q <= phase_i;
        tap_q   <= tap_i;
        if (rd_q && (phase_q == PH_WT)) begin
            wt_q[tap_q] <= rdata_i;
        end
    end

    assign prod = $signed(rdata_i) * wt_q[tap_q];

    // low half of the product, so the sum wraps at 32 bits
    always_ff @(posedge clk) begin
        if (rst_i || acc_clr_i) begin
            acc_q <= '0;
        end else if (rd_q && (phase_q == PH_IFM)) begin
            acc_q <= acc_q + prod[`CONV_DWIDTH-1:0];
        end
    end

    assign sum_o = acc_q;    // complete in the write cycle

endmodule

// ==== rtl/conv_dmem.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_dmem import conv_pkg::*; #(
    parameter int MEM_DEPTH = 16384
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic [`CONV_AWIDTH-1:0]     host_addr_i,
    input  logic [`CONV_DWIDTH-1:0]     host_wdata_i,
    input  logic [`CONV_DWIDTH/8-1:0]   host_be_i,
    input  logic                        host_re_i,
    input  logic                        busy_i,
    input  logic [`CONV_MEM_AWIDTH-1:0] eng_addr_i,
    input  logic                        eng_rd_i,
    input  logic                        eng_wr_i,
    input  logic [`CONV_DWIDTH-1:0]     eng_wdata_i,
    output logic [`CONV_DWIDTH-1:0]     rdata_o
);
    logic [`CONV_DWIDTH-1:0]     mem [MEM_DEPTH];
    logic [`CONV_AWIDTH-1:0]     host_off;
    logic                        host_hit;
    logic [`CONV_MEM_AWIDTH-1:0] a_addr;
    logic [`CONV_DWIDTH/8-1:0]   a_we;
    logic                        a_re;
    logic                        b_we;
    logic [`CONV_DWIDTH-1:0]     rdata_q;

    assign host_off = host_addr_i - `CONV_DMEM_BASE;
    assign host_hit = host_off < (MEM_DEPTH * 4);

    // port A is host-owned while idle, engine reads while busy
    assign a_addr = busy_i ? eng_addr_i : host_off[`CONV_MEM_AWIDTH+1:2];
    assign a_we   = (!busy_i && host_hit) ? host_be_i : '0;
    assign a_re   = busy_i ? eng_rd_i : (host_re_i && host_hit);
    assign b_we   = busy_i && eng_wr_i;    // port B only takes engine writes

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CONV_DWIDTH/8; i++) begin
            if (a_we[i]) begin
                mem[a_addr][8*i +: 8] <= host_wdata_i[8*i +: 8];
            end
        end
        if (b_we) begin
            mem[eng_addr_i] <= eng_wdata_i;
        end
        if (a_re) begin
            rdata_q <= mem[a_addr];    // read-first
        end
    end

    assign rdata_o = rdata_q;

    // the fsm strobes must only appear while the csr side sees the engine busy
    a_eng_when_busy : assert property (@(posedge clk) disable iff (rst_i)
        (eng_rd_i || eng_wr_i) |-> busy_i);

endmodule

// ==== rtl/conv_top.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_top (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic [`CONV_AWIDTH-1:0]   host_addr_i,
    input  logic [`CONV_DWIDTH-1:0]   host_wdata_i,
    input  logic [`CONV_DWIDTH/8-1:0] host_be_i,
    input  logic                      host_re_i,
    output logic [`CONV_DWIDTH-1:0]   host_rdata_o
);
    logic                         start;
    logic                         soft_rst;
    logic                         idle;
    logic                         done;
    logic                         busy;
    logic [`CONV_DWIDTH-1:0]      wt_offset;
    logic [`CONV_DWIDTH-1:0]      ifm_offset;
    logic [`CONV_DWIDTH-1:0]      ofm_offset;
    conv_pkg::conv_phase_t        phase;
    logic [`CONV_TAP_W-1:0]       tap;
    logic [`CONV_POS_W-1:0]       row;
    logic [`CONV_POS_W-1:0]       col;
    logic                         eng_rd;
    logic                         eng_wr;
    logic                         acc_clr;
    logic [`CONV_MEM_AWIDTH-1:0]  eng_addr;
    logic [`CONV_DWIDTH-1:0]      sum;
    logic [`CONV_DWIDTH-1:0]      mem_rdata;

    assign busy = ~idle;    // engine owns port A while running

    conv_csr i_conv_csr (
        .clk          (clk),
        .rst_i        (rst_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_be_i    (host_be_i),
        .host_re_i    (host_re_i),
        .mem_rdata_i  (mem_rdata),
        .idle_i       (idle),
        .done_i       (done),
        .start_o      (start),
        .soft_rst_o   (soft_rst),
        .wt_offset_o  (wt_offset),
        .ifm_offset_o (ifm_offset),
        .ofm_offset_o (ofm_offset),
        .host_rdata_o (host_rdata_o)
    );

    conv_fsm i_conv_fsm (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (start),
        .soft_rst_i (soft_rst),
        .phase_o    (phase),
        .tap_o      (tap),
        .row_o      (row),
        .col_o      (col),
        .rd_o       (eng_rd),
        .wr_o       (eng_wr),
        .acc_clr_o  (acc_clr),
        .idle_o     (idle),
        .done_o     (done)
    );

    conv_addr_gen i_conv_addr_gen (
        .phase_i      (phase),
        .tap_i        (tap),
        .row_i        (row),
        .col_i        (col),
        .wt_offset_i  (wt_offset),
        .ifm_offset_i (ifm_offset),
        .ofm_offset_i (ofm_offset),
        .addr_o       (eng_addr)
    );

    conv_mac i_conv_mac (
        .clk       (clk),
        .rst_i     (rst_i),
        .phase_i   (phase),
        .tap_i     (tap),
        .rd_i      (eng_rd),
        .acc_clr_i (acc_clr),
        .rdata_i   (mem_rdata),
        .sum_o     (sum)
    );

    conv_dmem #(
        .MEM_DEPTH (`CONV_MEM_DEPTH)
    ) i_conv_dmem (
        .clk          (clk),
        .rst_i        (rst_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_be_i    (host_be_i),
        .host_re_i    (host_re_i),
        .busy_i       (busy),
        .eng_addr_i   (eng_addr),
        .eng_rd_i     (eng_rd),
        .eng_wr_i     (eng_wr),
        .eng_wdata_i  (sum),
        .rdata_o      (mem_rdata)
    );

endmodule

// ==== tb/conv_checker.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_checker import conv_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic [`CONV_AWIDTH-1:0]   host_addr_i,
    input  logic [`CONV_DWIDTH-1:0]   host_wdata_i,
    input  logic [`CONV_DWIDTH/8-1:0] host_be_i,
    input  logic                      host_re_i,
    input  logic [`CONV_DWIDTH-1:0]   host_rdata_i,
    output int                        checks_o,
    output int                        errors_o
);
    localparam int TAPS      = `CONV_WT_DIM * `CONV_WT_DIM;
    localparam int NUM_OUT   = `CONV_OUT_DIM * `CONV_OUT_DIM;
    localparam int RUN_EDGES = (TAPS + 1) + NUM_OUT * (TAPS + 2);    // weight load, then outputs

    logic [`CONV_DWIDTH-1:0] shadow [`CONV_MEM_DEPTH];
    logic [`CONV_DWIDTH-1:0] ref_out [NUM_OUT];
    logic [`CONV_DWIDTH-1:0] wt_off;
    logic [`CONV_DWIDTH-1:0] ifm_off;
    logic [`CONV_DWIDTH-1:0] ofm_off;
    logic                    idle_m;
    logic                    done_m;
    logic                    start_pend;
    logic                    soft_pend;
    logic                    new_start;
    logic                    new_soft;
    int                      run_left;
    logic                    rd_pend;
    logic [`CONV_AWIDTH-1:0] rd_addr_q;
    logic [`CONV_DWIDTH-1:0] exp_q;

    function automatic logic [`CONV_MEM_AWIDTH-1:0] word_of(input logic [31:0] base,
                                                            input int idx);
        logic [31:0] a;
        a = base + idx;
        return a[`CONV_MEM_AWIDTH-1:0];    // engine addresses wrap at memory size
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    // one output point as the wrapped sum of nine products
    function automatic logic [31:0] conv_point(input int r, input int c);
        logic [31:0] acc;
        logic [31:0] pix;
        logic [31:0] wt;
        acc = '0;
        for (int ky = 0; ky < `CONV_WT_DIM; ky++) begin
            for (int kx = 0; kx < `CONV_WT_DIM; kx++) begin
                pix = shadow[word_of(ifm_off, (r + ky) * `CONV_FM_DIM + c + kx)];
                wt  = shadow[word_of(wt_off, ky * `CONV_WT_DIM + kx)];
                acc = acc + pix * wt;    // low 32 bits match the signed product
            end
        end
        return acc;
    endfunction

    function automatic logic [31:0] expect_read(input logic [31:0] addr);
        logic [31:0]  reg_off;
        logic [31:0]  mem_off;
        conv_status_t st;
        reg_off = addr - `CONV_CSR_BASE;
        mem_off = addr - `CONV_DMEM_BASE;
        st      = '0;
        st.idle = idle_m;
        st.done = done_m;
        if (reg_off <= `CONV_REG_OFM && reg_off[1:0] == 2'b00) begin
            case (reg_off)
                `CONV_REG_STATUS: return st;
                `CONV_REG_WT:     return wt_off;
                `CONV_REG_IFM:    return ifm_off;
                `CONV_REG_OFM:    return ofm_off;
                default:          return '0;
            endcase
        end
        return shadow[mem_off[`CONV_MEM_AWIDTH+1:2]];
    endfunction

    task automatic apply_write();
        logic [31:0] reg_off;
        logic [31:0] mem_off;
        reg_off = host_addr_i - `CONV_CSR_BASE;
        mem_off = host_addr_i - `CONV_DMEM_BASE;
        if (reg_off <= `CONV_REG_OFM && reg_off[1:0] == 2'b00) begin
            case (reg_off)
                `CONV_REG_CTRL: begin
                    new_soft  = host_wdata_i[1];
                    new_start = host_wdata_i[0] && !host_wdata_i[1];    // soft reset wins
                end
                `CONV_REG_WT:  wt_off  = merge_bytes(wt_off, host_wdata_i, host_be_i);
                `CONV_REG_IFM: ifm_off = merge_bytes(ifm_off, host_wdata_i, host_be_i);
                `CONV_REG_OFM: ofm_off = merge_bytes(ofm_off, host_wdata_i, host_be_i);
                default:       ;
            endcase
        end else if (mem_off < `CONV_MEM_DEPTH * 4 && idle_m) begin
            shadow[mem_off[`CONV_MEM_AWIDTH+1:2]] =
                merge_bytes(shadow[mem_off[`CONV_MEM_AWIDTH+1:2]], host_wdata_i, host_be_i);
        end
    endtask

    // engine status one edge behind the control pulses
    task automatic step_engine();
        if (soft_pend) begin
            idle_m   = 1'b1;
            done_m   = 1'b0;
            run_left = 0;
        end else if (start_pend && idle_m) begin
            idle_m   = 1'b0;
            done_m   = 1'b0;
            run_left = RUN_EDGES;
            for (int k = 0; k < NUM_OUT; k++) begin
                ref_out[k] = conv_point(k / `CONV_OUT_DIM, k % `CONV_OUT_DIM);
            end
        end else if (!idle_m) begin
            run_left--;
            if (run_left == 0) begin
                idle_m = 1'b1;
                done_m = 1'b1;
                for (int k = 0; k < NUM_OUT; k++) begin
                    shadow[word_of(ofm_off, k)] = ref_out[k];
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            wt_off     = `CONV_WT_OFFSET_RST;
            ifm_off    = `CONV_IFM_OFFSET_RST;
            ofm_off    = `CONV_OFM_OFFSET_RST;
            idle_m     = 1'b1;
            done_m     = 1'b0;
            start_pend = 1'b0;
            soft_pend  = 1'b0;
            run_left   = 0;
            rd_pend    = 1'b0;
            checks_o   = 0;
            errors_o   = 0;
        end else begin
            if (rd_pend) begin
                checks_o++;
                if (host_rdata_i !== exp_q) begin
                    errors_o++;
                    $display("Error at time %0t: host_rdata_o expected %h, actual %h (addr %h)",
                             $time, exp_q, host_rdata_i, rd_addr_q);
                end
            end
            rd_pend = host_re_i;
            if (host_re_i) begin
                exp_q     = expect_read(host_addr_i);    // values before this edge's write
                rd_addr_q = host_addr_i;
            end
            new_start = 1'b0;
            new_soft  = 1'b0;
            if (|host_be_i) begin
                apply_write();
            end
            step_engine();
            start_pend = new_start;
            soft_pend  = new_soft;
        end
    end

endmodule

// ==== tb/tb_conv_top.sv ====
`timescale 1ns/1ps
`include "conv_settings.svh"

module tb_conv_top import conv_pkg::*; ();
    localparam int POLL_LIMIT = 300;
    localparam int NUM_TESTS  = 4;
    localparam int TAPS       = `CONV_WT_DIM * `CONV_WT_DIM;
    localparam int NUM_PIX    = `CONV_FM_DIM * `CONV_FM_DIM;
    localparam int NUM_OUT    = `CONV_OUT_DIM * `CONV_OUT_DIM;

    typedef struct {
        string name;
        int    wt_off;
        int    ifm_off;
        int    ofm_off;
        bit    full_range;
        bit    soft_mid;
    } test_row_t;

    logic                      clk;
    logic                      rst_i;
    logic [`CONV_AWIDTH-1:0]   host_addr_i;
    logic [`CONV_DWIDTH-1:0]   host_wdata_i;
    logic [`CONV_DWIDTH/8-1:0] host_be_i;
    logic                      host_re_i;
    logic [`CONV_DWIDTH-1:0]   host_rdata_o;
    int                        checks;
    int                        errors;
    int                        timeouts;
    int                        tests_run;
    int                        err_mark;
    int                        seed;
    logic [`CONV_DWIDTH-1:0]   rdata;
    test_row_t                 test_table [NUM_TESTS];

    conv_top i_conv_top (
        .clk          (clk),
        .rst_i        (rst_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_be_i    (host_be_i),
        .host_re_i    (host_re_i),
        .host_rdata_o (host_rdata_o)
    );

    conv_checker i_conv_checker (
        .clk          (clk),
        .rst_i        (rst_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_be_i    (host_be_i),
        .host_re_i    (host_re_i),
        .host_rdata_i (host_rdata_o),
        .checks_o     (checks),
        .errors_o     (errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] mem_addr(input int word);
        return `CONV_DMEM_BASE + word * 4;
    endfunction

    function automatic logic [31:0] reg_addr(input int off);
        return `CONV_CSR_BASE + off;
    endfunction

    task automatic host_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
        @(posedge clk);
        host_addr_i  <= addr;
        host_wdata_i <= data;
        host_be_i    <= be;
        @(posedge clk);
        host_be_i    <= '0;
    endtask

    task automatic host_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        host_addr_i <= addr;
        host_re_i   <= 1'b1;
        @(posedge clk);
        host_re_i   <= 1'b0;
        @(negedge clk);
        data = host_rdata_o;    // settled one cycle after the strobe
    endtask

    // mask and want are {done, idle}
    task automatic poll_status(input logic [1:0] mask, input logic [1:0] want,
                               input string what);
        int           polls;
        conv_status_t st;
        polls = 0;
        do begin
            host_read(reg_addr(`CONV_REG_STATUS), rdata);
            st = conv_status_t'(rdata);
            polls++;
        end while ((({st.done, st.idle} & mask) !== want) && polls < POLL_LIMIT);
        if (({st.done, st.idle} & mask) !== want) begin
            $display("timeout: %s did not happen within %0d status polls", what, POLL_LIMIT);
            timeouts++;
        end
    endtask

    task automatic check_reset_state();
        host_read(reg_addr(`CONV_REG_STATUS), rdata);
        host_read(reg_addr(`CONV_REG_CTRL), rdata);
        host_read(reg_addr(`CONV_REG_WT), rdata);
        host_read(reg_addr(`CONV_REG_IFM), rdata);
        host_read(reg_addr(`CONV_REG_OFM), rdata);
    endtask

    task automatic check_bus_writes();
        host_write(mem_addr(300), 32'h1122_3344, 4'hf);
        host_write(mem_addr(300), 32'hAABB_CCDD, 4'b0101);    // bytes 0 and 2 only
        host_read(mem_addr(300), rdata);
        host_write(mem_addr(301), 32'h5566_7788, 4'hf);
        host_write(mem_addr(301), 32'h99EE_0000, 4'b1000);
        host_read(mem_addr(301), rdata);
        host_write(reg_addr(`CONV_REG_WT), 32'h0000_0123, 4'hf);
        host_write(reg_addr(`CONV_REG_WT), 32'h0000_4500, 4'b0010);
        host_read(reg_addr(`CONV_REG_WT), rdata);
        host_write(reg_addr(`CONV_REG_IFM), 32'h0000_0abc, 4'hf);
        host_read(reg_addr(`CONV_REG_IFM), rdata);
        host_write(reg_addr(`CONV_REG_OFM), 32'h0000_0def, 4'hf);
        host_read(reg_addr(`CONV_REG_OFM), rdata);
    endtask

    task automatic load_row(input test_row_t row);
        logic [31:0] v;
        int          word;
        host_write(reg_addr(`CONV_REG_WT), row.wt_off, 4'hf);
        host_write(reg_addr(`CONV_REG_IFM), row.ifm_off, 4'hf);
        host_write(reg_addr(`CONV_REG_OFM), row.ofm_off, 4'hf);
        for (int i = 0; i < TAPS + NUM_PIX; i++) begin
            v = $random(seed);
            if (!row.full_range) begin
                v = $signed(v) % 8;    // small signed, -7..7
            end
            word = (i < TAPS) ? row.wt_off + i : row.ifm_off + i - TAPS;
            host_write(mem_addr(word), v, 4'hf);
        end
    endtask

    task automatic read_back(input test_row_t row);
        for (int i = 0; i < TAPS; i++) begin
            host_read(mem_addr(row.wt_off + i), rdata);
        end
        for (int i = 0; i < NUM_PIX; i++) begin
            host_read(mem_addr(row.ifm_off + i), rdata);
        end
        for (int i = 0; i < NUM_OUT; i++) begin
            host_read(mem_addr(row.ofm_off + i), rdata);
        end
    endtask

    task automatic run_row(input test_row_t row);
        load_row(row);
        host_write(reg_addr(`CONV_REG_CTRL), 32'h1, 4'hf);
        poll_status(2'b11, 2'b00, "engine start");
        if (row.soft_mid) begin
            host_write(reg_addr(`CONV_REG_CTRL), 32'h2, 4'hf);
            poll_status(2'b11, 2'b01, "return to idle after soft reset");
            host_write(reg_addr(`CONV_REG_CTRL), 32'h1, 4'hf);
            poll_status(2'b11, 2'b00, "engine restart after soft reset");
        end
        poll_status(2'b11, 2'b11, "job completion");
        read_back(row);
    endtask

    task automatic end_test(input string name);
        int bad;
        @(posedge clk);
        @(negedge clk);    // last read compare lands
        bad = errors + timeouts - err_mark;
        tests_run++;
        if (bad == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d problems", name, bad);
        end
        err_mark = errors + timeouts;
    endtask

    initial begin
        seed         = 46;
        timeouts     = 0;
        tests_run    = 0;
        err_mark     = 0;
        rst_i        = 1'b1;
        host_addr_i  = '0;
        host_wdata_i = '0;
        host_be_i    = '0;
        host_re_i    = 1'b0;
        // name, wt, ifm, ofm, full range, soft reset midway
        test_table[0] = '{"default_small", 0, 9, 73, 1'b0, 1'b0};
        test_table[1] = '{"relocated_full", 2000, 3000, 4100, 1'b1, 1'b0};
        test_table[2] = '{"soft_reset_mid", 0, 9, 73, 1'b0, 1'b1};
        test_table[3] = '{"restart_after_done", 500, 700, 900, 1'b1, 1'b0};
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        check_reset_state();
        end_test("reset_defaults");
        check_bus_writes();
        end_test("bus_writes");
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_row(test_table[i]);
            end_test(test_table[i].name);
        end
        $display("summary: %0d tests, %0d reads compared, %0d mismatches, %0d timeouts",
                 tests_run, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
rtl/conv_pkg.sv
rtl/conv_addr_gen.sv
rtl/conv_csr.sv
rtl/conv_fsm.sv
rtl/conv_mac.sv
rtl/conv_dmem.sv
rtl/conv_top.sv
tb/conv_checker.sv
tb/tb_conv_top.sv
